// File: verilog.f
rtl/bus_pkg.sv
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_decoder.sv
rtl/exec_unit.sv
rtl/fetch_unit.sv
rtl/mem_arbiter.sv
rtl/uart_rx.sv
rtl/soc_top.sv
testbench/soc_properties.sv
testbench/soc_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vsoc_tb: verilog.f $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module soc_tb -o Vsoc_tb

run: obj_dir/Vsoc_tb
	./obj_dir/Vsoc_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module soc_tb

clean:
	rm -rf obj_dir sim.log

// File: testbench/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

	localparam int CYCLE_LIMIT = 4000; // About 45 instructions at up to 15 clocks plus the byte
	localparam logic [31:0] STORE_BASE = 32'h0000_0200;
	localparam int NUM_STORES = 15;
	localparam logic [31:0] JAL_PC = 32'd124;

	logic clk = 1'b0;
	logic nRst;
	logic mem_ack;
	logic [31:0] mem_rdata;
	logic rx;
	logic mem_req;
	bus_pkg::bus_req_t mem_out;
	logic illegal_instr;

	logic [31:0] mem [0:255];
	logic [31:0] expected [0:NUM_STORES-1];
	logic seen [0:NUM_STORES-1];
	logic pending = 1'b0;
	logic [1:0] ack_wait = 2'd0;
	int errors = 0;
	int cycles = 0;

	soc_top UUT (
		.clk(clk),
		.nRst(nRst),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.rx(rx),
		.mem_req(mem_req),
		.mem_out(mem_out),
		.illegal_instr(illegal_instr)
	);

	bind soc_top soc_properties props (
		.clk(clk),
		.nRst(nRst),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.mem_out(mem_out),
		.illegal_instr(illegal_instr),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] imm_op(input int op, input int f3, input int rd,
			input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] store_op(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch_op(input int f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] lui_op(input int rd, input int upper);
		return {upper[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] jal_op(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic load_program();
		int i;
		for (i = 0; i < 256; i++)
			mem[i] = 32'hC0DE_0000 ^ 32'(i * 4);
		mem[0] = imm_op('h13, 0, 1, 0, 1234); // x1 = 1234
		mem[1] = imm_op('h13, 0, 2, 0, -77); // x2 = -77
		mem[2] = reg_op(0, 0, 3, 1, 2); // add
		mem[3] = store_op(3, 0, 'h200);
		mem[4] = reg_op('h20, 0, 3, 1, 2); // sub
		mem[5] = store_op(3, 0, 'h204);
		mem[6] = imm_op('h13, 1, 3, 2, 3); // slli by 3
		mem[7] = store_op(3, 0, 'h208);
		mem[8] = imm_op('h13, 5, 3, 2, 'h402); // srai by 2
		mem[9] = store_op(3, 0, 'h20C);
		mem[10] = reg_op(0, 5, 3, 2, 1); // srl x2 by x1
		mem[11] = store_op(3, 0, 'h210);
		mem[12] = reg_op(0, 2, 3, 2, 1); // slt
		mem[13] = store_op(3, 0, 'h214);
		mem[14] = reg_op(0, 3, 3, 2, 1); // sltu
		mem[15] = store_op(3, 0, 'h218);
		mem[16] = reg_op(0, 4, 3, 1, 2); // xor
		mem[17] = store_op(3, 0, 'h21C);
		mem[18] = reg_op(0, 6, 3, 1, 2); // or
		mem[19] = store_op(3, 0, 'h220);
		mem[20] = imm_op('h13, 7, 3, 2, 'h0F0); // andi
		mem[21] = store_op(3, 0, 'h224);
		mem[22] = lui_op(3, 'hABCDE);
		mem[23] = store_op(3, 0, 'h228);
		mem[24] = imm_op('h13, 0, 4, 0, 5); // Loop counter
		mem[25] = imm_op('h13, 0, 7, 0, 0); // Pass count
		mem[26] = imm_op('h13, 0, 7, 7, 1);
		mem[27] = imm_op('h13, 0, 4, 4, -1);
		mem[28] = branch_op(1, 4, 0, -8); // bne back to 104
		mem[29] = store_op(4, 0, 'h22C);
		mem[30] = store_op(7, 0, 'h230);
		mem[31] = jal_op(8, 8); // Skips the next word
		mem[32] = imm_op('h13, 0, 8, 0, 0);
		mem[33] = store_op(8, 0, 'h234);
		mem[34] = lui_op(5, 'h10);
		mem[35] = imm_op('h13, 0, 5, 5, -4); // x5 = UART register
		mem[36] = imm_op('h03, 2, 6, 5, 0); // Poll with lw
		mem[37] = imm_op('h13, 7, 9, 6, 'h100);
		mem[38] = branch_op(0, 9, 0, -8); // beq back to the poll
		mem[39] = store_op(6, 0, 'h238);
		mem[40] = 32'h0000_0000; // Illegal, halts the core
	endtask

	task automatic set_expected();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'd1234;
		b = -32'd77;
		expected[0] = a + b;
		expected[1] = a - b;
		expected[2] = b << 3;
		expected[3] = $signed(b) >>> 2;
		expected[4] = b >> a[4:0];
		expected[5] = {31'b0, $signed(b) < $signed(a)};
		expected[6] = {31'b0, b < a};
		expected[7] = a ^ b;
		expected[8] = a | b;
		expected[9] = b & 32'h0000_00F0;
		expected[10] = {20'hABCDE, 12'h000};
		expected[11] = 32'd0;
		expected[12] = 32'd5;
		expected[13] = JAL_PC + 32'd4;
		expected[14] = (32'd1 << bus_pkg::UART_VALID_BIT) | 32'h0000_00A5;
		for (int i = 0; i < NUM_STORES; i++)
			seen[i] = 1'b0;
	endtask

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		int slot;
		if (addr < STORE_BASE || addr >= STORE_BASE + 4 * NUM_STORES) begin
			errors++;
			$display("Store of %h to unexpected address %h at %0t", data, addr, $time);
		end else begin
			slot = int'((addr - STORE_BASE) >> 2);
			seen[slot] = 1'b1;
			assert (data == expected[slot]) else begin
				errors++;
				$display("Mismatch at %0t: mem_out.wdata to %h got %h expected %h",
					$time, addr, data, expected[slot]);
			end
		end
	endtask

	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0}; // Stop, data, start
		for (i = 0; i < 10; i++) begin
			rx <= frame[i];
			repeat (bus_pkg::UART_CYCLES_PER_BIT) @(posedge clk);
		end
	endtask

	task automatic report_counts();
		$display("Closing counts: %0d store errors, %0d assertion failures",
			errors, UUT.props.fail_count);
	endtask

	// Memory model with a random four-phase ack delay
	always @(posedge clk) begin
		if (!nRst) begin
			mem_ack <= 1'b0;
			pending <= 1'b0;
		end else if (mem_ack) begin
			if (!mem_req)
				mem_ack <= 1'b0;
		end else if (mem_req) begin
			if (!pending) begin
				pending <= 1'b1;
				ack_wait <= 2'($urandom_range(3, 0));
			end else if (ack_wait != 2'd0) begin
				ack_wait <= ack_wait - 2'd1;
			end else begin
				pending <= 1'b0;
				mem_ack <= 1'b1;
				if (mem_out.we) begin
					mem[mem_out.addr[9:2]] = mem_out.wdata;
					check_store(mem_out.addr, mem_out.wdata);
				end else begin
					mem_rdata <= mem[mem_out.addr[9:2]];
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
			report_counts();
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		void'($urandom(75245));
		nRst <= 1'b0;
		rx <= 1'b1;
		mem_ack <= 1'b0;
		mem_rdata <= '0;
		load_program();
		set_expected();
		repeat (3) @(posedge clk);
		nRst <= 1'b1;
		repeat (4) @(posedge clk);
		send_byte(8'hA5);
		while (!illegal_instr)
			@(posedge clk);
		repeat (40) @(posedge clk); // Halt must stay quiet
		for (int i = 0; i < NUM_STORES; i++) begin
			assert (seen[i]) else begin
				errors++;
				$display("Store to address %h never happened", STORE_BASE + 32'(i * 4));
			end
		end
		report_counts();
		if (errors == 0 && UUT.props.fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: testbench/soc_properties.sv
`timescale 1ns/1ps

module soc_properties (
	input logic clk,
	input logic nRst,
	input logic mem_req,
	input logic mem_ack,
	input bus_pkg::bus_req_t mem_out,
	input logic illegal_instr,
	input logic redirect,
	input logic [bus_pkg::XLEN-1:0] redirect_pc,
	input logic instr_valid,
	input logic [bus_pkg::XLEN-1:0] instr_pc
);
	int fail_count = 0;
	logic seen_req;
	logic awaiting; // Redirect seen, target word not yet buffered
	logic [bus_pkg::XLEN-1:0] target;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			seen_req <= 1'b0;
			awaiting <= 1'b0;
		end else begin
			if (mem_req)
				seen_req <= 1'b1;
			if (redirect)
				awaiting <= 1'b1;
			else if (instr_valid)
				awaiting <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect)
			target <= redirect_pc;
	end

	reset_quiet: assert property (@(posedge clk) (!nRst || !$past(nRst)) |-> !mem_req)
		else begin
			fail_count++;
			$error("mem_req high during or just after reset");
		end

	first_read: assert property (@(posedge clk) disable iff (!nRst)
		(mem_req && !seen_req) |-> (mem_out.addr == '0 && !mem_out.we))
		else begin
			fail_count++;
			$error("First request is not a read of address 0");
		end

	out_stable: assert property (@(posedge clk) disable iff (!nRst)
		mem_req |=> (!mem_req || $stable(mem_out)))
		else begin
			fail_count++;
			$error("mem_out changed while mem_req was high");
		end

	req_until_ack: assert property (@(posedge clk) disable iff (!nRst)
		(mem_req && !mem_ack) |=> mem_req)
		else begin
			fail_count++;
			$error("mem_req dropped before mem_ack");
		end

	no_early_req: assert property (@(posedge clk) disable iff (!nRst)
		(!mem_req && mem_ack) |=> !mem_req)
		else begin
			fail_count++;
			$error("mem_req rose while mem_ack was still high");
		end

	no_uart_on_bus: assert property (@(posedge clk) disable iff (!nRst)
		mem_req |-> mem_out.addr != bus_pkg::UART_ADDR)
		else begin
			fail_count++;
			$error("UART register address reached the external port");
		end

	branch_target: assert property (@(posedge clk) disable iff (!nRst)
		(awaiting && instr_valid) |-> instr_pc == target)
		else begin
			fail_count++;
			$error("Instruction after a taken branch or jal is not from its target");
		end

	halt_sticky: assert property (@(posedge clk) disable iff (!nRst)
		illegal_instr |=> illegal_instr)
		else begin
			fail_count++;
			$error("illegal_instr fell after rising");
		end

	halt_quiet: assert property (@(posedge clk) disable iff (!nRst)
		illegal_instr |-> !mem_req)
		else begin
			fail_count++;
			$error("Memory request issued after the core halted");
		end

endmodule

// File: rtl/soc_top.sv
`timescale 1ns/1ps

module soc_top (
	input logic clk,
	input logic nRst,
	input logic mem_ack,
	input logic [bus_pkg::XLEN-1:0] mem_rdata,
	input logic rx,
	output logic mem_req,
	output bus_pkg::bus_req_t mem_out,
	output logic illegal_instr
);
	logic fetch_req;
	logic fetch_done;
	bus_pkg::bus_req_t fetch_bus;
	logic data_req;
	logic data_done;
	bus_pkg::bus_req_t data_bus;
	logic [bus_pkg::XLEN-1:0] rdata;
	logic instr_valid;
	logic instr_take;
	logic [bus_pkg::XLEN-1:0] instr;
	logic [bus_pkg::XLEN-1:0] instr_pc;
	logic redirect;
	logic [bus_pkg::XLEN-1:0] redirect_pc;
	logic [bus_pkg::XLEN-1:0] uart_word;
	logic uart_read;

	fetch_unit fetch (
		.clk(clk),
		.nRst(nRst),
		.done(fetch_done),
		.rdata(rdata),
		.instr_take(instr_take),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.req(fetch_req),
		.bus(fetch_bus),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc)
	);

	exec_unit exec (
		.clk(clk),
		.nRst(nRst),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.done(data_done),
		.rdata(rdata),
		.instr_take(instr_take),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.req(data_req),
		.bus(data_bus),
		.illegal_instr(illegal_instr)
	);

	mem_arbiter arbiter (
		.clk(clk),
		.nRst(nRst),
		.fetch_req(fetch_req),
		.fetch_bus(fetch_bus),
		.data_req(data_req),
		.data_bus(data_bus),
		.uart_word(uart_word),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.fetch_done(fetch_done),
		.data_done(data_done),
		.rdata(rdata),
		.uart_read(uart_read),
		.mem_req(mem_req),
		.mem_out(mem_out)
	);

	uart_rx uart (
		.clk(clk),
		.nRst(nRst),
		.rx(rx),
		.uart_read(uart_read),
		.uart_word(uart_word)
	);

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic clk,
	input logic nRst,
	input logic rx,
	input logic uart_read,
	output logic [bus_pkg::XLEN-1:0] uart_word
);
	typedef logic [$clog2(bus_pkg::UART_CYCLES_PER_BIT)-1:0] tick_t;

	tick_t tick;
	logic busy;
	logic [3:0] bit_cnt; // 0 start, 1 to 8 data, 9 stop
	logic [7:0] shift;
	logic [7:0] rx_byte;
	logic valid;
	logic sample;

	assign sample = busy && tick == tick_t'(bus_pkg::UART_CYCLES_PER_BIT - 1);

	always_comb begin
		uart_word = '0;
		uart_word[7:0] = rx_byte;
		uart_word[bus_pkg::UART_VALID_BIT] = valid;
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			busy <= 1'b0;
			tick <= '0;
			bit_cnt <= '0;
			valid <= 1'b0;
		end else begin
			if (uart_read)
				valid <= 1'b0;
			if (!busy) begin
				if (!rx) begin
					busy <= 1'b1;
					tick <= tick_t'(bus_pkg::UART_CYCLES_PER_BIT / 2); // Half bit to mid start
					bit_cnt <= '0;
				end
			end else if (sample) begin
				tick <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'd0 && rx)
					busy <= 1'b0; // Glitch, not a start bit
				else if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					if (rx)
						valid <= 1'b1; // Wins over a read in the same cycle
				end
			end else begin
				tick <= tick + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			shift <= {rx, shift[7:1]}; // LSB first
		if (sample && bit_cnt == 4'd9 && rx)
			rx_byte <= shift;
	end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input logic clk,
	input logic nRst,
	input logic fetch_req,
	input bus_pkg::bus_req_t fetch_bus,
	input logic data_req,
	input bus_pkg::bus_req_t data_bus,
	input logic [bus_pkg::XLEN-1:0] uart_word,
	input logic mem_ack,
	input logic [bus_pkg::XLEN-1:0] mem_rdata,
	output logic fetch_done,
	output logic data_done,
	output logic [bus_pkg::XLEN-1:0] rdata,
	output logic uart_read,
	output logic mem_req,
	output bus_pkg::bus_req_t mem_out
);
	typedef enum logic [1:0] {A_IDLE, A_REQ, A_RELEASE} arb_state_t;

	arb_state_t state;
	logic data_owner; // Holder of the external grant
	logic uart_hit;
	logic answering;

	assign uart_hit = data_bus.addr == bus_pkg::UART_ADDR;

	// A client still shows its old request during its done cycle
	assign answering = fetch_done || data_done;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= A_IDLE;
			mem_req <= 1'b0;
			data_owner <= 1'b0;
			fetch_done <= 1'b0;
			data_done <= 1'b0;
			uart_read <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			data_done <= 1'b0;
			uart_read <= 1'b0;
			case (state)
				A_IDLE: begin
					if (!answering) begin
						if (data_req && uart_hit) begin
							data_done <= 1'b1; // Local answer, port untouched
							uart_read <= 1'b1;
						end else if (data_req || fetch_req) begin
							mem_req <= 1'b1;
							data_owner <= data_req; // Data before fetch
							state <= A_REQ;
						end
					end
				end
				A_REQ: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						fetch_done <= !data_owner;
						data_done <= data_owner;
						state <= A_RELEASE;
					end
				end
				A_RELEASE: if (!mem_ack) state <= A_IDLE; // Four-phase return to zero
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == A_IDLE)
			mem_out <= data_req ? data_bus : fetch_bus; // Frozen once mem_req is up
		if (state == A_IDLE && data_req && uart_hit)
			rdata <= uart_word;
		else if (state == A_REQ && mem_ack)
			rdata <= mem_rdata;
	end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input logic clk,
	input logic nRst,
	input logic done,
	input logic [bus_pkg::XLEN-1:0] rdata,
	input logic instr_take,
	input logic redirect,
	input logic [bus_pkg::XLEN-1:0] redirect_pc,
	output logic req,
	output bus_pkg::bus_req_t bus,
	output logic instr_valid,
	output logic [bus_pkg::XLEN-1:0] instr,
	output logic [bus_pkg::XLEN-1:0] instr_pc
);
	logic busy; // Request outstanding at the arbiter
	logic drop; // Outstanding word made stale by a redirect
	logic buf_valid;
	logic [bus_pkg::XLEN-1:0] fetch_pc;
	logic [bus_pkg::XLEN-1:0] resume_pc;
	logic [bus_pkg::XLEN-1:0] buf_instr;
	logic [bus_pkg::XLEN-1:0] buf_pc;

	// Prefetch as soon as the buffer is empty or being taken
	assign req = busy || !buf_valid || instr_take;

	assign bus.we = 1'b0;
	assign bus.addr = fetch_pc;
	assign bus.wdata = '0;

	assign instr_valid = buf_valid;
	assign instr = buf_instr;
	assign instr_pc = buf_pc;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			busy <= 1'b0;
			drop <= 1'b0;
			buf_valid <= 1'b0;
			fetch_pc <= '0;
		end else begin
			busy <= req && !done;
			if (redirect)
				drop <= 1'b1;
			else if (done)
				drop <= 1'b0;
			if (instr_take || redirect)
				buf_valid <= 1'b0;
			else if (done && !drop)
				buf_valid <= 1'b1;
			if (done)
				fetch_pc <= drop ? resume_pc : fetch_pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect)
			resume_pc <= redirect_pc;
		if (done && !drop) begin
			buf_instr <= rdata;
			buf_pc <= fetch_pc;
		end
	end

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input logic clk,
	input logic nRst,
	input logic instr_valid,
	input logic [bus_pkg::XLEN-1:0] instr,
	input logic [bus_pkg::XLEN-1:0] instr_pc,
	input logic done,
	input logic [bus_pkg::XLEN-1:0] rdata,
	output logic instr_take,
	output logic redirect,
	output logic [bus_pkg::XLEN-1:0] redirect_pc,
	output logic req,
	output bus_pkg::bus_req_t bus,
	output logic illegal_instr
);
	typedef enum logic [1:0] {E_TAKE, E_WB, E_MEM, E_HALT} exec_state_t;

	exec_state_t state;
	rv_pkg::decoded_t dec;
	logic [bus_pkg::XLEN-1:0] regs [0:31];
	logic [bus_pkg::XLEN-1:0] rs1_val;
	logic [bus_pkg::XLEN-1:0] rs2_val;
	logic [bus_pkg::XLEN-1:0] alu_b;
	logic [bus_pkg::XLEN-1:0] alu_result;
	logic [bus_pkg::XLEN-1:0] wb_value;
	logic [bus_pkg::XLEN-1:0] wb_data;
	logic [4:0] wb_rd;
	logic wb_en;
	logic take_branch;

	rv_decoder decoder (
		.instr(instr),
		.dec(dec)
	);

	assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
	assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
	assign alu_b = dec.use_imm ? dec.imm : rs2_val;

	rv_alu alu (
		.op(dec.alu_op),
		.a(rs1_val),
		.b(alu_b),
		.result(alu_result),
		.take_branch(take_branch)
	);

	// An illegal word is never taken, so the fetch unit stops with it
	assign instr_take = (state == E_TAKE) && instr_valid && !dec.illegal;
	assign redirect = instr_take && (dec.jump || (dec.branch && take_branch));
	assign redirect_pc = instr_pc + dec.imm;
	assign req = (state == E_MEM);

	always_comb begin
		case (dec.wb_src)
			rv_pkg::WB_IMM: wb_value = dec.imm;
			rv_pkg::WB_LINK: wb_value = instr_pc + 32'd4;
			default: wb_value = alu_result; // Load data replaces it on done
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= E_TAKE;
			wb_en <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			case (state)
				E_TAKE: begin
					if (instr_valid && dec.illegal) begin
						illegal_instr <= 1'b1;
						state <= E_HALT;
					end else if (instr_take) begin
						wb_en <= dec.reg_write;
						state <= (dec.load || dec.store) ? E_MEM : E_WB;
					end
				end
				E_MEM: if (done) state <= E_WB;
				E_WB: state <= E_TAKE;
				default: state <= E_HALT; // Stays halted until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (instr_take) begin
			wb_rd <= dec.rd;
			wb_data <= wb_value;
			bus <= '{we: dec.store, addr: alu_result, wdata: rs2_val};
		end else if (state == E_MEM && done) begin
			wb_data <= rdata;
		end
		if (state == E_WB && wb_en && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

endmodule

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input logic [bus_pkg::XLEN-1:0] instr,
	output rv_pkg::decoded_t dec
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [bus_pkg::XLEN-1:0] imm_i;
	logic [bus_pkg::XLEN-1:0] imm_s;
	logic [bus_pkg::XLEN-1:0] imm_b;
	logic [bus_pkg::XLEN-1:0] imm_u;
	logic [bus_pkg::XLEN-1:0] imm_j;

	function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: return rv_pkg::ALU_SLL;
			3'b010: return rv_pkg::ALU_SLT;
			3'b011: return rv_pkg::ALU_SLTU;
			3'b100: return rv_pkg::ALU_XOR;
			3'b101: return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: return rv_pkg::ALU_OR;
			default: return rv_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd = instr[11:7];
		case (opcode)
			rv_pkg::OP_LUI: begin
				dec.imm = imm_u;
				dec.reg_write = 1'b1;
				dec.wb_src = rv_pkg::WB_IMM;
			end
			rv_pkg::OP_JAL: begin
				dec.imm = imm_j;
				dec.jump = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_src = rv_pkg::WB_LINK;
			end
			rv_pkg::OP_BRANCH: begin
				dec.imm = imm_b;
				dec.branch = 1'b1;
				case (funct3)
					3'b000: dec.alu_op = rv_pkg::ALU_BEQ;
					3'b001: dec.alu_op = rv_pkg::ALU_BNE;
					3'b100: dec.alu_op = rv_pkg::ALU_BLT;
					3'b101: dec.alu_op = rv_pkg::ALU_BGE;
					default: dec.illegal = 1'b1; // Unsigned branches not kept
				endcase
			end
			rv_pkg::OP_LOAD: begin
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.load = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_src = rv_pkg::WB_MEM;
				dec.illegal = funct3 != 3'b010; // Word only
			end
			rv_pkg::OP_STORE: begin
				dec.imm = imm_s;
				dec.use_imm = 1'b1;
				dec.store = 1'b1;
				dec.illegal = funct3 != 3'b010;
			end
			rv_pkg::OP_IMM: begin
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
				dec.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001)
					dec.illegal = funct7 != 7'h00;
				else if (funct3 == 3'b101)
					dec.illegal = funct7 != 7'h00 && funct7 != 7'h20;
			end
			rv_pkg::OP_REG: begin
				dec.reg_write = 1'b1;
				dec.alu_op = arith_op(funct3, funct7[5]);
				dec.illegal = funct7 != 7'h00 &&
					!(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			default: dec.illegal = 1'b1;
		endcase
	end

endmodule

// File: rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input rv_pkg::alu_op_t op,
	input logic [bus_pkg::XLEN-1:0] a,
	input logic [bus_pkg::XLEN-1:0] b,
	output logic [bus_pkg::XLEN-1:0] result,
	output logic take_branch
);
	logic [$clog2(bus_pkg::XLEN)-1:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = b[$clog2(bus_pkg::XLEN)-1:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		result = '0;
		take_branch = 1'b0;
		case (op)
			rv_pkg::ALU_ADD: result = a + b;
			rv_pkg::ALU_SUB: result = a - b;
			rv_pkg::ALU_SLL: result = a << shamt;
			rv_pkg::ALU_SLT: result = {{(bus_pkg::XLEN-1){1'b0}}, lt_signed};
			rv_pkg::ALU_SLTU: result = {{(bus_pkg::XLEN-1){1'b0}}, lt_unsigned};
			rv_pkg::ALU_XOR: result = a ^ b;
			rv_pkg::ALU_SRL: result = a >> shamt;
			rv_pkg::ALU_SRA: result = $signed(a) >>> shamt; // Sign fill
			rv_pkg::ALU_OR: result = a | b;
			rv_pkg::ALU_AND: result = a & b;
			rv_pkg::ALU_BEQ: take_branch = a == b;
			rv_pkg::ALU_BNE: take_branch = a != b;
			rv_pkg::ALU_BLT: take_branch = lt_signed;
			rv_pkg::ALU_BGE: take_branch = !lt_signed;
			default: result = '0;
		endcase
	end

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE // Branch compares
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_IMM, WB_LINK
	} wb_src_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [bus_pkg::XLEN-1:0] imm;
		alu_op_t alu_op;
		logic use_imm; // Operand b from imm instead of rs2
		logic reg_write;
		wb_src_t wb_src;
		logic jump;
		logic branch;
		logic load;
		logic store;
		logic illegal;
	} decoded_t;

endpackage

// File: rtl/bus_pkg.sv
package bus_pkg;

	localparam int XLEN = 32;

	// UART receive register, answered inside the arbiter
	localparam logic [XLEN-1:0] UART_ADDR = 32'h0000_FFFC;

	// Serial bit length in clocks
	localparam int UART_CYCLES_PER_BIT = 8;

	// Fresh byte flag in the word read from UART_ADDR
	localparam int UART_VALID_BIT = 8;

	typedef struct packed {
		logic we;
		logic [XLEN-1:0] addr; // Byte address of a word, low bits zero
		logic [XLEN-1:0] wdata;
	} bus_req_t;

endpackage
